//--- cpu.f
verilog/cpu_pkg.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/ex_stage.sv
verilog/mem_stage.sv
verilog/wb_stage.sv
verilog/regfile.sv
verilog/cpu.sv
tb/cpu_sva.sv
tb/cpu_tb.sv

//--- run_verilator.sh
#!/bin/sh
# build the cpu testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpu_tb -f cpu.f -o cpu_tb_sim || exit 1
out="$(./obj_dir/cpu_tb_sim)"
echo "$out"
echo "$out" | grep -qx "TESTBENCH PASSED" && echo "run passed" || { echo "run failed"; exit 1; }

//--- tb/cpu_tb.sv
// cpu_tb: clock, reset, fetch and data memory models with random latency, program, store checks
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

  localparam int NUM_STORES = 11;
  localparam int TIMEOUT = 2000;

  logic        clock;
  logic        reset;
  mem_req_t    if_req;
  logic        if_valid;
  logic        if_ready = 1'b0;
  logic [31:0] if_rdata = '0;
  mem_req_t    mem_req;
  logic        mem_valid;
  logic        mem_ready = 1'b0;
  logic [63:0] mem_rdata = '0;
  logic        halted;

  logic [31:0] imem [256];
  logic [63:0] dmem [1024];
  logic [63:0] exp_addr [NUM_STORES];
  logic [63:0] exp_data [NUM_STORES];
  string       exp_name [NUM_STORES];

  logic [31:0] seed;
  logic        fetch_busy;
  logic [1:0]  fetch_wait;
  logic        data_busy;
  logic [1:0]  data_wait;
  int          store_count;
  int          write_errors;
  int          run_errors;
  int          cycles;

  cpu u_dut (
    .clock, .reset, .if_req, .if_valid, .if_ready, .if_rdata,
    .mem_req, .mem_valid, .mem_ready, .mem_rdata, .halted
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // instruction formats of the base isa
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'd3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'h37};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic load_program();
    for (int k = 0; k < 256; k++)
      imem[k] = 32'h0000_0013;
    imem[0]  = u_type(20'h00001, 5'd10);                      // x10 = 0x1000
    imem[1]  = i_type(12'd100, 5'd0, 3'd0, 5'd1, 7'h13);      // x1 = 100
    imem[2]  = i_type(12'hff9, 5'd0, 3'd0, 5'd2, 7'h13);      // x2 = -7
    imem[3]  = r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3);         // add, mem and wb distance
    imem[4]  = s_type(12'd0, 5'd3, 5'd10);
    imem[5]  = r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd4);         // sub
    imem[6]  = s_type(12'd8, 5'd4, 5'd10);
    imem[7]  = u_type(20'h12345, 5'd5);
    imem[8]  = r_type(7'h00, 5'd1, 5'd5, 3'd4, 5'd6);         // xor
    imem[9]  = s_type(12'd16, 5'd6, 5'd10);
    imem[10] = r_type(7'h00, 5'd2, 5'd6, 3'd7, 5'd7);         // and
    imem[11] = s_type(12'd24, 5'd7, 5'd10);
    imem[12] = r_type(7'h00, 5'd1, 5'd2, 3'd6, 5'd8);         // or
    imem[13] = s_type(12'd32, 5'd8, 5'd10);
    imem[14] = u_type(20'h80000, 5'd11);                      // sign extends on rv64
    imem[15] = i_type(12'h123, 5'd11, 3'd0, 5'd11, 7'h13);
    imem[16] = s_type(12'd40, 5'd11, 5'd10);
    imem[17] = i_type(12'h800, 5'd10, 3'd3, 5'd12, 7'h03);    // ld from 0x800
    imem[18] = r_type(7'h00, 5'd1, 5'd12, 3'd0, 5'd13);       // load-use
    imem[19] = s_type(12'd48, 5'd13, 5'd10);
    imem[20] = i_type(12'd0, 5'd10, 3'd3, 5'd14, 7'h03);      // reads back store 0
    imem[21] = r_type(7'h00, 5'd14, 5'd14, 3'd0, 5'd15);
    imem[22] = s_type(12'd56, 5'd15, 5'd10);
    imem[23] = b_type(13'd8, 5'd1, 5'd1, 3'd0);               // beq taken
    imem[24] = s_type(12'd64, 5'd0, 5'd10);                   // wrong path
    imem[25] = b_type(13'd8, 5'd2, 5'd1, 3'd1);               // bne taken
    imem[26] = s_type(12'd72, 5'd0, 5'd10);                   // wrong path
    imem[27] = b_type(13'd8, 5'd2, 5'd1, 3'd0);               // beq falls through
    imem[28] = s_type(12'd64, 5'd1, 5'd10);
    imem[29] = b_type(13'd8, 5'd3, 5'd3, 3'd1);               // bne falls through
    imem[30] = s_type(12'd72, 5'd2, 5'd10);
    imem[31] = j_type(21'd12, 5'd16);                         // jal to 0x88
    imem[32] = s_type(12'd80, 5'd0, 5'd10);
    imem[33] = s_type(12'd88, 5'd0, 5'd10);
    imem[34] = s_type(12'd80, 5'd16, 5'd10);
    imem[35] = 32'h0000_006b;                                 // halt
    imem[36] = s_type(12'd96, 5'd1, 5'd10);                   // never executes
  endtask

  task automatic add_expected(input int n, input string name, input logic [63:0] addr,
                              input logic [63:0] data);
    exp_name[n] = name;
    exp_addr[n] = addr;
    exp_data[n] = data;
  endtask

  // worked out by hand from the program above
  task automatic fill_reference();
    add_expected(0, "add_forward", 64'h1000, 64'h5d);
    add_expected(1, "sub", 64'h1008, 64'h6b);
    add_expected(2, "lui_xor", 64'h1010, 64'h1234_5064);
    add_expected(3, "and", 64'h1018, 64'h1234_5060);
    add_expected(4, "or", 64'h1020, 64'hffff_ffff_ffff_fffd);
    add_expected(5, "lui_addi", 64'h1028, 64'hffff_ffff_8000_0123);
    add_expected(6, "load_use", 64'h1030, 64'hffff_f7ff_0000_0864);
    add_expected(7, "store_load", 64'h1038, 64'hba);
    add_expected(8, "beq_fall_through", 64'h1040, 64'h64);
    add_expected(9, "bne_fall_through", 64'h1048, 64'hffff_ffff_ffff_fff9);
    add_expected(10, "jal_link", 64'h1050, 64'h80);
  endtask

  task automatic check_store(input logic [63:0] addr, input logic [63:0] data);
    dmem[addr[12:3]] = data;
    if (halted) begin
      write_errors++;
      $display("data write of %h to %h after the core halted", data, addr);
    end
    if (store_count >= NUM_STORES) begin
      write_errors++;
      $display("unexpected data write of %h to %h after the last expected store", data, addr);
    end else begin
      assert (addr == exp_addr[store_count]) else begin
        write_errors++;
        $display("Error: %s address, expected %h, actual %h", exp_name[store_count],
                 exp_addr[store_count], addr);
      end
      assert (data == exp_data[store_count]) else begin
        write_errors++;
        $display("Error: %s data, expected %h, actual %h", exp_name[store_count],
                 exp_data[store_count], data);
      end
    end
    store_count++;
  endtask

  // both memories, ready after a random wait of 0 to 3 cycles
  always @(posedge clock) begin
    if (reset) begin
      if_ready  <= 1'b0;
      mem_ready <= 1'b0;
      fetch_busy = 1'b0;
      fetch_wait = 2'd0;
      data_busy = 1'b0;
      data_wait = 2'd0;
      seed = 32'h31ca6fb6;
      store_count = 0;
      write_errors = 0;
      // every doubleword holds its own byte address
      for (int k = 0; k < 1024; k++)
        dmem[k] = {~(k * 8), k * 8};
    end else begin
      if (if_ready) begin
        if_ready <= 1'b0;
        fetch_busy = 1'b0;
      end else if (if_valid) begin
        if (!fetch_busy) begin
          seed = next_rand(seed);
          fetch_wait = seed[17:16];
          fetch_busy = 1'b1;
        end
        if (fetch_wait == 2'd0) begin
          if_ready <= 1'b1;
          if_rdata <= imem[if_req.addr[9:2]];
        end else begin
          fetch_wait = fetch_wait - 2'd1;
        end
      end
      if (mem_ready) begin
        mem_ready <= 1'b0;
        data_busy = 1'b0;
        if (mem_req.write)
          check_store(mem_req.addr, mem_req.wdata);
      end else if (mem_valid) begin
        if (!data_busy) begin
          seed = next_rand(seed);
          data_wait = seed[17:16];
          data_busy = 1'b1;
        end
        if (data_wait == 2'd0) begin
          mem_ready <= 1'b1;
          mem_rdata <= dmem[mem_req.addr[12:3]];
        end else begin
          data_wait = data_wait - 2'd1;
        end
      end
    end
  end

  initial begin
    reset <= 1'b1;
    run_errors = 0;
    cycles = 0;
    load_program();
    fill_reference();
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    while (!halted && cycles < TIMEOUT) begin
      @(posedge clock);
      cycles++;
    end
    if (!halted) begin
      run_errors++;
      $display("timeout, the core did not halt within %0d cycles", TIMEOUT);
    end else begin
      // late writes would show up here
      repeat (20) @(posedge clock);
      assert (halted) else begin
        run_errors++;
        $display("halted went low after the halt retired");
      end
    end
    assert (store_count == NUM_STORES) else begin
      run_errors++;
      $display("Error: store_count, expected %0d, actual %0d", NUM_STORES, store_count);
    end
    $display("write errors %0d, run errors %0d, total errors %0d", write_errors, run_errors,
             write_errors + run_errors);
    if (write_errors + run_errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/cpu_sva.sv
// cpu_sva: memory port stability and request fields, idle ports after reset, halted hold, bind
`timescale 1ns/1ps
`default_nettype none

module cpu_sva import cpu_pkg::*; (
  input logic     clock,
  input logic     reset,
  input mem_req_t if_req,
  input logic     if_valid,
  input logic     if_ready,
  input mem_req_t mem_req,
  input logic     mem_valid,
  input logic     mem_ready,
  input logic     halted
);

  // a pending request keeps valid and its fields until ready
  fetch_stable: assert property (@(posedge clock) disable iff (reset)
    if_valid && !if_ready |=> if_valid && $stable(if_req))
    else $error("fetch request dropped or changed before if_ready");

  data_stable: assert property (@(posedge clock) disable iff (reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
    else $error("data request dropped or changed before mem_ready");

  // fetch is a word read, data accesses are doublewords
  fetch_kind: assert property (@(posedge clock) disable iff (reset)
    if_valid |-> !if_req.write && if_req.size == 2'd2)
    else $error("fetch request is not a word read");

  data_size: assert property (@(posedge clock) disable iff (reset)
    mem_valid |-> mem_req.size == 2'd3)
    else $error("data request is not a doubleword access");

  reset_idle: assert property (@(posedge clock)
    reset |=> !if_valid && !mem_valid && !halted)
    else $error("memory port active or halted set in the cycle after reset");

  // sticky until the next reset
  halted_hold: assert property (@(posedge clock) halted && !reset |=> halted)
    else $error("halted fell without reset");

endmodule

bind cpu cpu_sva u_sva (
  .clock(clock), .reset(reset), .if_req(if_req), .if_valid(if_valid), .if_ready(if_ready),
  .mem_req(mem_req), .mem_valid(mem_valid), .mem_ready(mem_ready), .halted(halted)
);

`default_nettype wire

//--- verilog/cpu.sv
// cpu: top level with the five pipeline stages, register file and memory ports
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  output mem_req_t          if_req,
  output logic              if_valid,
  input  logic              if_ready,
  input  logic [INST_W-1:0] if_rdata,
  output mem_req_t          mem_req,
  output logic              mem_valid,
  input  logic              mem_ready,
  input  logic [XLEN-1:0]   mem_rdata,
  output logic              halted
);

  // stage handshakes
  logic       if_to_id_valid, id_to_ex_valid, ex_to_mem_valid, mem_to_wb_valid;
  logic       id_allowin, ex_allowin, mem_allowin, wb_allowin;
  if_to_id_t  if_to_id;
  id_to_ex_t  id_to_ex;
  ex_to_mem_t ex_to_mem;
  mem_to_wb_t mem_to_wb;

  // control and forwarding
  bj_ctrl_t   bj_ctrl;
  logic       halt_seen;
  fwd_t       mem_forward, wb_forward;

  // register file ports
  logic [4:0]      rs1_addr, rs2_addr, reg_waddr;
  logic [XLEN-1:0] rs1_data, rs2_data, reg_wdata;
  logic            reg_wen;

  if_stage u_if (
    .clock, .reset, .bj_ctrl, .halt_seen, .id_allowin,
    .if_to_id_valid, .if_to_id, .if_req, .if_valid, .if_ready, .if_rdata
  );

  id_stage u_id (
    .clock, .reset, .if_to_id_valid, .if_to_id, .id_allowin,
    .flush (bj_ctrl.taken),
    .id_to_ex_valid, .id_to_ex, .ex_allowin
  );

  ex_stage u_ex (
    .clock, .reset, .id_to_ex_valid, .id_to_ex, .ex_allowin,
    .ex_to_mem_valid, .ex_to_mem, .mem_allowin, .mem_forward, .wb_forward,
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .bj_ctrl, .halt_seen
  );

  mem_stage u_mem (
    .clock, .reset, .ex_to_mem_valid, .ex_to_mem, .mem_allowin,
    .mem_to_wb_valid, .mem_to_wb, .wb_allowin, .mem_forward,
    .mem_req, .mem_valid, .mem_ready, .mem_rdata
  );

  wb_stage u_wb (
    .clock, .reset, .mem_to_wb_valid, .mem_to_wb, .wb_allowin, .wb_forward,
    .reg_wen, .reg_waddr, .reg_wdata, .halted
  );

  regfile u_regfile (
    .clock, .reset, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .reg_wen, .reg_waddr, .reg_wdata
  );

endmodule

`default_nettype wire

//--- verilog/regfile.sv
// regfile: 32 x 64 general purpose registers, two read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module regfile import cpu_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic [4:0]      rs1_addr,
  input  logic [4:0]      rs2_addr,
  output logic [XLEN-1:0] rs1_data,
  output logic [XLEN-1:0] rs2_data,
  input  logic            reg_wen,
  input  logic [4:0]      reg_waddr,
  input  logic [XLEN-1:0] reg_wdata
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int n = 0; n < 32; n++)
        regs[n] <= '0;
    end else if (reg_wen && reg_waddr != 5'd0) begin
      regs[reg_waddr] <= reg_wdata;
    end
  end

  // x0 is hardwired
  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- verilog/wb_stage.sv
// wb_stage: register file write, wb forwarding and the halted flag
`timescale 1ns/1ps
`default_nettype none

module wb_stage import cpu_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            mem_to_wb_valid,
  input  mem_to_wb_t      mem_to_wb,
  output logic            wb_allowin,
  output fwd_t            wb_forward,
  output logic            reg_wen,
  output logic [4:0]      reg_waddr,
  output logic [XLEN-1:0] reg_wdata,
  output logic            halted
);

  logic       valid;
  mem_to_wb_t q;

  // retires every cycle, never stalls
  assign wb_allowin = 1'b1;

  assign reg_wen = valid && q.reg_wen;
  assign reg_waddr = q.rd;
  assign reg_wdata = q.wdata;
  assign wb_forward = '{valid: reg_wen && q.rd != 5'd0, rd: q.rd, data: q.wdata};

  always_ff @(posedge clock) begin
    if (reset) begin
      valid  <= 1'b0;
      halted <= 1'b0;
    end else begin
      if (wb_allowin)
        valid <= mem_to_wb_valid;
      if (valid && q.inst[6:0] == OP_HALT)
        halted <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wb_allowin && mem_to_wb_valid)
      q <= mem_to_wb;
  end

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
// mem_stage: doubleword load and store requests, result select and mem forwarding
`timescale 1ns/1ps
`default_nettype none

module mem_stage import cpu_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            ex_to_mem_valid,
  input  ex_to_mem_t      ex_to_mem,
  output logic            mem_allowin,
  output logic            mem_to_wb_valid,
  output mem_to_wb_t      mem_to_wb,
  input  logic            wb_allowin,
  output fwd_t            mem_forward,
  output mem_req_t        mem_req,
  output logic            mem_valid,
  input  logic            mem_ready,
  input  logic [XLEN-1:0] mem_rdata
);

  logic            valid;
  ex_to_mem_t      q;
  logic            need_mem;
  logic            done;
  logic            ready_go;
  logic [XLEN-1:0] rdata_q;
  logic [XLEN-1:0] wdata;

  assign need_mem = q.is_load || q.is_store;
  // done keeps a finished access from being issued twice under back-pressure
  assign ready_go = !need_mem || done || mem_ready;
  assign mem_allowin = !valid || (ready_go && wb_allowin);
  assign mem_to_wb_valid = valid && ready_go;

  assign mem_valid = valid && need_mem && !done;
  assign mem_req = '{addr: q.alu_result, wdata: q.store_data, write: q.is_store, size: 2'd3};

  assign wdata = !q.is_load ? q.alu_result : done ? rdata_q : mem_rdata;
  assign mem_to_wb = '{pc: q.pc, inst: q.inst, rd: q.rd, wdata: wdata, reg_wen: q.reg_wen};
  assign mem_forward = '{valid: mem_to_wb_valid && q.reg_wen && q.rd != 5'd0,
                         rd: q.rd, data: wdata};

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= 1'b0;
      done  <= 1'b0;
    end else begin
      if (mem_allowin)
        valid <= ex_to_mem_valid;
      if (mem_allowin)
        done <= 1'b0;
      else if (mem_valid && mem_ready)
        done <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_allowin && ex_to_mem_valid)
      q <= ex_to_mem;
    if (mem_valid && mem_ready)
      rdata_q <= mem_rdata;
  end

endmodule

`default_nettype wire

//--- verilog/ex_stage.sv
// ex_stage: operand forwarding, load-use stall, alu, branch and jump resolution
`timescale 1ns/1ps
`default_nettype none

module ex_stage import cpu_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            id_to_ex_valid,
  input  id_to_ex_t       id_to_ex,
  output logic            ex_allowin,
  output logic            ex_to_mem_valid,
  output ex_to_mem_t      ex_to_mem,
  input  logic            mem_allowin,
  input  fwd_t            mem_forward,
  input  fwd_t            wb_forward,
  output logic [4:0]      rs1_addr,
  output logic [4:0]      rs2_addr,
  input  logic [XLEN-1:0] rs1_data,
  input  logic [XLEN-1:0] rs2_data,
  output bj_ctrl_t        bj_ctrl,
  output logic            halt_seen
);

  logic            valid;
  id_to_ex_t       q;
  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_out;
  logic            load_in_mem;
  logic [4:0]      load_rd;
  logic            stall;
  logic            fire;
  logic            eq;

  // youngest producer wins
  function automatic logic [XLEN-1:0] pick(input logic [4:0] rs, input logic [XLEN-1:0] rf,
                                           input fwd_t fm, input fwd_t fw);
    if (fm.valid && fm.rd == rs)
      return fm.data;
    if (fw.valid && fw.rd == rs)
      return fw.data;
    return rf;
  endfunction

  assign rs1_addr = q.rs1;
  assign rs2_addr = q.rs2;
  assign src1 = pick(q.rs1, rs1_data, mem_forward, wb_forward);
  assign src2 = pick(q.rs2, rs2_data, mem_forward, wb_forward);
  assign op_b = q.use_imm ? q.imm : src2;

  // load in mem whose data has not come back yet
  assign stall = load_in_mem && !mem_forward.valid && (load_rd == q.rs1 || load_rd == q.rs2);
  assign ex_allowin = !valid || (!stall && mem_allowin);
  assign ex_to_mem_valid = valid && !stall;
  assign fire = ex_to_mem_valid && mem_allowin;

  always_comb begin
    case (q.alu_op)
      ALU_SUB:    alu_out = src1 - op_b;
      ALU_AND:    alu_out = src1 & op_b;
      ALU_OR:     alu_out = src1 | op_b;
      ALU_XOR:    alu_out = src1 ^ op_b;
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = src1 + op_b;
    endcase
  end

  assign eq = src1 == src2;
  // halt also flushes so that nothing younger runs
  assign bj_ctrl.taken = fire && (q.is_jal || q.is_halt || (q.is_beq && eq) || (q.is_bne && !eq));
  assign bj_ctrl.target = q.pc + q.imm;
  assign halt_seen = fire && q.is_halt;

  assign ex_to_mem = '{pc: q.pc, inst: q.inst, rd: q.rd,
                       alu_result: q.is_jal ? q.pc + 64'd4 : alu_out,
                       store_data: src2, reg_wen: q.reg_wen,
                       is_load: q.is_load, is_store: q.is_store};

  always_ff @(posedge clock) begin
    if (reset) begin
      valid       <= 1'b0;
      load_in_mem <= 1'b0;
      load_rd     <= 5'd0;
    end else begin
      if (ex_allowin)
        valid <= id_to_ex_valid;
      // mirrors what mem holds after this edge
      if (mem_allowin) begin
        load_in_mem <= fire && q.is_load && q.rd != 5'd0;
        load_rd     <= q.rd;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ex_allowin && id_to_ex_valid)
      q <= id_to_ex;
  end

endmodule

`default_nettype wire

//--- verilog/id_stage.sv
// id_stage: instruction register, decode of the subset and immediate generation
`timescale 1ns/1ps
`default_nettype none

module id_stage import cpu_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      if_to_id_valid,
  input  if_to_id_t if_to_id,
  output logic      id_allowin,
  input  logic      flush,
  output logic      id_to_ex_valid,
  output id_to_ex_t id_to_ex,
  input  logic      ex_allowin
);

  logic              valid;
  if_to_id_t         q;
  logic [INST_W-1:0] i;
  logic [XLEN-1:0]   imm_i;
  logic [XLEN-1:0]   imm_s;
  logic [XLEN-1:0]   imm_b;
  logic [XLEN-1:0]   imm_u;
  logic [XLEN-1:0]   imm_j;

  assign i = q.inst;
  assign imm_i = {{52{i[31]}}, i[31:20]};
  assign imm_s = {{52{i[31]}}, i[31:25], i[11:7]};
  assign imm_b = {{51{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
  assign imm_u = {{32{i[31]}}, i[31:12], 12'b0};
  assign imm_j = {{43{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};

  assign id_allowin = !valid || ex_allowin;
  assign id_to_ex_valid = valid && !flush;

  always_comb begin
    id_to_ex = '0;
    id_to_ex.pc = q.pc;
    id_to_ex.inst = i;
    id_to_ex.rs1 = i[19:15];
    id_to_ex.rs2 = i[24:20];
    id_to_ex.rd = i[11:7];
    id_to_ex.alu_op = ALU_ADD;
    // anything not matched below passes as a no-op
    case (i[6:0])
      OP_OP: begin
        id_to_ex.reg_wen = 1'b1;
        case (i[14:12])
          F3_ADD:  id_to_ex.alu_op = i[30] ? ALU_SUB : ALU_ADD;
          F3_XOR:  id_to_ex.alu_op = ALU_XOR;
          F3_OR:   id_to_ex.alu_op = ALU_OR;
          F3_AND:  id_to_ex.alu_op = ALU_AND;
          default: id_to_ex.reg_wen = 1'b0;
        endcase
      end
      OP_IMM: begin
        id_to_ex.reg_wen = i[14:12] == F3_ADD;
        id_to_ex.use_imm = 1'b1;
        id_to_ex.imm = imm_i;
      end
      OP_LUI: begin
        id_to_ex.reg_wen = 1'b1;
        id_to_ex.use_imm = 1'b1;
        id_to_ex.alu_op = ALU_PASS_B;
        id_to_ex.imm = imm_u;
      end
      OP_LOAD: begin
        id_to_ex.is_load = i[14:12] == F3_DWORD;
        id_to_ex.reg_wen = i[14:12] == F3_DWORD;
        id_to_ex.use_imm = 1'b1;
        id_to_ex.imm = imm_i;
      end
      OP_STORE: begin
        id_to_ex.is_store = i[14:12] == F3_DWORD;
        id_to_ex.use_imm = 1'b1;
        id_to_ex.imm = imm_s;
      end
      OP_BRANCH: begin
        id_to_ex.is_beq = i[14:12] == F3_BEQ;
        id_to_ex.is_bne = i[14:12] == F3_BNE;
        id_to_ex.imm = imm_b;
      end
      OP_JAL: begin
        id_to_ex.is_jal = 1'b1;
        id_to_ex.reg_wen = 1'b1;
        id_to_ex.imm = imm_j;
      end
      OP_HALT: id_to_ex.is_halt = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset || flush)
      valid <= 1'b0;
    else if (id_allowin)
      valid <= if_to_id_valid;
  end

  always_ff @(posedge clock) begin
    if (id_allowin && if_to_id_valid)
      q <= if_to_id;
  end

endmodule

`default_nettype wire

//--- verilog/if_stage.sv
// if_stage: pc, fetch request handshake, output skid register, redirect and halt
`timescale 1ns/1ps
`default_nettype none

module if_stage import cpu_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  bj_ctrl_t          bj_ctrl,
  input  logic              halt_seen,
  input  logic              id_allowin,
  output logic              if_to_id_valid,
  output if_to_id_t         if_to_id,
  output mem_req_t          if_req,
  output logic              if_valid,
  input  logic              if_ready,
  input  logic [INST_W-1:0] if_rdata
);

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] req_addr;
  logic [XLEN-1:0] fetch_pc;
  logic            busy;
  logic            drop;
  logic            stopped;
  logic            out_valid;
  if_to_id_t       out_q;
  logic            resp_ok;
  logic            hold_next;
  logic            issue;

  // a response is usable unless it is stale or killed by a redirect now
  assign resp_ok = busy && if_ready && !drop && !bj_ctrl.taken;
  assign if_to_id_valid = (out_valid || resp_ok) && !bj_ctrl.taken;
  assign if_to_id = out_valid ? out_q : '{pc: req_addr, inst: if_rdata};

  // item stays here when id cannot take it
  assign hold_next = !bj_ctrl.taken && !id_allowin && (out_valid || resp_ok);
  assign issue = (!busy || if_ready) && !hold_next && !stopped && !halt_seen;
  assign fetch_pc = bj_ctrl.taken ? bj_ctrl.target : pc;

  assign if_valid = busy;
  assign if_req = '{addr: req_addr, wdata: '0, write: 1'b0, size: 2'd2};

  always_ff @(posedge clock) begin
    if (reset) begin
      pc        <= PC_START;
      busy      <= 1'b0;
      drop      <= 1'b0;
      stopped   <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= hold_next;
      if (halt_seen)
        stopped <= 1'b1;
      if (issue) begin
        busy <= 1'b1;
        pc   <= fetch_pc + 64'd4;
      end else begin
        if (if_ready)
          busy <= 1'b0;
        if (bj_ctrl.taken)
          pc <= bj_ctrl.target;
      end
      // outstanding fetch across a redirect returns stale data
      if (busy && if_ready)
        drop <= 1'b0;
      else if (busy && bj_ctrl.taken)
        drop <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (issue)
      req_addr <= fetch_pc;
    if (resp_ok && !id_allowin)
      out_q <= '{pc: req_addr, inst: if_rdata};
  end

endmodule

`default_nettype wire

//--- verilog/cpu_pkg.sv
// widths, opcodes, alu operations and stage payload structs for the cpu core
`default_nettype none

package cpu_pkg;

  localparam int XLEN = 64;
  localparam int INST_W = 32;
  localparam logic [XLEN-1:0] PC_START = 64'h0;

  // major opcodes of the supported subset
  localparam logic [6:0] OP_OP     = 7'h33;
  localparam logic [6:0] OP_IMM    = 7'h13;
  localparam logic [6:0] OP_LUI    = 7'h37;
  localparam logic [6:0] OP_LOAD   = 7'h03;
  localparam logic [6:0] OP_STORE  = 7'h23;
  localparam logic [6:0] OP_BRANCH = 7'h63;
  localparam logic [6:0] OP_JAL    = 7'h6f;
  localparam logic [6:0] OP_HALT   = 7'h6b;

  // funct3 values
  localparam logic [2:0] F3_ADD   = 3'd0;
  localparam logic [2:0] F3_XOR   = 3'd4;
  localparam logic [2:0] F3_OR    = 3'd6;
  localparam logic [2:0] F3_AND   = 3'd7;
  localparam logic [2:0] F3_BEQ   = 3'd0;
  localparam logic [2:0] F3_BNE   = 3'd1;
  localparam logic [2:0] F3_DWORD = 3'd3;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B
  } alu_op_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [INST_W-1:0] inst;
  } if_to_id_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [INST_W-1:0] inst;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [4:0]        rd;
    logic [XLEN-1:0]   imm;
    alu_op_t           alu_op;
    logic              use_imm;
    logic              reg_wen;
    logic              is_load;
    logic              is_store;
    logic              is_beq;
    logic              is_bne;
    logic              is_jal;
    logic              is_halt;
  } id_to_ex_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [INST_W-1:0] inst;
    logic [4:0]        rd;
    logic [XLEN-1:0]   alu_result;
    logic [XLEN-1:0]   store_data;
    logic              reg_wen;
    logic              is_load;
    logic              is_store;
  } ex_to_mem_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [INST_W-1:0] inst;
    logic [4:0]        rd;
    logic [XLEN-1:0]   wdata;
    logic              reg_wen;
  } mem_to_wb_t;

  typedef struct packed {
    logic            valid;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } fwd_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } bj_ctrl_t;

  // request of a memory port, size is log2 of the byte count
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            write;
    logic [1:0]      size;
  } mem_req_t;

endpackage

`default_nettype wire
